// File: filelist.f
design/tc_pkg.sv
design/tc_header_parser.sv
design/tc_input_fifo.sv
design/tc_queue_fifo.sv
design/tc_pair_writer.sv
design/tc_drain_ctrl.sv
design/tail_cache.sv
test/tb_tail_cache.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_tail_cache
RTL_TOP   ?= tail_cache
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tb_tail_cache.sv
// Tail cache testbench
`timescale 1ns/1ps

module tb_tail_cache;
   import tc_pkg::*;

   localparam int TIMEOUT_CYCLES = 2000;

   typedef logic [WORD_WIDTH-1:0] word_q_t [$];
   typedef logic [PAIR_WIDTH-1:0] pair_q_t [$];

   logic                   clk;
   logic                   reset;
   logic [DATA_WIDTH-1:0]  in_data;
   logic [CTRL_WIDTH-1:0]  in_ctrl;
   logic                   in_wr;
   logic                   in_rdy;
   logic                   dram_rd;
   logic [QUEUE_BITS-1:0]  dram_queue;
   logic                   dram_wr_rdy;
   logic                   dram_wr;
   logic [PAIR_WIDTH-1:0]  dram_data;
   logic [NUM_QUEUES-1:0]  hc_rdy;
   logic [NUM_QUEUES-1:0]  hc_wr;
   logic [PAIR_WIDTH-1:0]  hc_data [NUM_QUEUES];
   logic [COUNT_WIDTH-1:0] occup_cnt [NUM_QUEUES];
   logic [NUM_QUEUES-1:0]  occup_blk;

   // expected pairs and model occupancy per queue
   logic [PAIR_WIDTH-1:0] exp_q [NUM_QUEUES][$];
   int                    model_cnt [NUM_QUEUES];
   int                    errors;
   int                    checked;
   int                    dropped;
   int                    dram_pairs;
   logic                  xfer_active;
   int                    xfer_queue;
   string                 test_name;

   // head cache and DRAM ready models
   logic [NUM_QUEUES-1:0] hc_mask;
   logic                  hc_toggle;
   logic                  dram_toggle;
   logic [31:0]           lcg_state;

   tail_cache UUT (
      .clk(clk), .reset(reset), .in_data(in_data), .in_ctrl(in_ctrl),
      .in_wr(in_wr), .in_rdy(in_rdy), .dram_rd(dram_rd), .dram_queue(dram_queue),
      .dram_wr_rdy(dram_wr_rdy), .dram_wr(dram_wr), .dram_data(dram_data),
      .hc_rdy(hc_rdy), .hc_wr(hc_wr), .hc_data(hc_data), .occup_cnt(occup_cnt),
      .occup_blk(occup_blk)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   // ------------------------------------------------------------------------
   // random numbers and reference model
   // ------------------------------------------------------------------------
   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic int random_range(input int lo, input int hi);
      logic [31:0] r;
      r = next_random();
      return lo + int'(r[31:16]) % (hi - lo + 1);
   endfunction

   // earlier word in the upper half and an odd last word padded with zero
   function automatic pair_q_t pack_pairs(input word_q_t words);
      pair_q_t pairs;
      for (int i = 0; i < words.size(); i += 2) begin
         if (i + 1 < words.size()) begin
            pairs.push_back({words[i], words[i+1]});
         end else begin
            pairs.push_back({words[i], {WORD_WIDTH{1'b0}}});
         end
      end
      return pairs;
   endfunction

   // ------------------------------------------------------------------------
   // reporting
   // ------------------------------------------------------------------------
   task automatic end_run();
      $display("summary: %0d errors, %0d pairs checked, %0d drops", errors, checked, dropped);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout in %s: %s", test_name, what);
      errors++;
      end_run();
   endtask

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (expected == actual) else begin
         $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what,
                  expected, actual);
         errors++;
      end
   endtask

   task automatic check_pair(input int q, input logic [PAIR_WIDTH-1:0] actual,
                             input string path);
      logic [PAIR_WIDTH-1:0] expected;
      expected = '0;
      assert (exp_q[q].size() > 0) else begin
         $display("Error in %s: %s pair from queue %0d with none expected", test_name,
                  path, q);
         errors++;
      end
      if (exp_q[q].size() > 0) begin
         expected = exp_q[q].pop_front();
         model_cnt[q]--;
         checked++;
         assert (actual == expected) else begin
            $display("** Error [%s] %s pair of queue %0d: expected %h, actual %h",
                     test_name, path, q, expected, actual);
            errors++;
         end
      end
   endtask

   // ------------------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------------------
   task automatic next_cycle();
      logic [31:0] r1;
      logic [31:0] r2;
      @(posedge clk);
      #2;
      r1 = next_random();
      r2 = next_random();
      hc_rdy = hc_mask;
      if (hc_toggle) begin
         // each enabled bit ready about three cycles in four
         hc_rdy = hc_mask & (NUM_QUEUES'(r1 >> 16) | NUM_QUEUES'(r2 >> 16));
      end
      dram_wr_rdy = dram_toggle & r1[27];
   endtask

   task automatic write_word(input logic [WORD_WIDTH-1:0] word);
      int waited;
      waited = 0;
      while (!in_rdy) begin
         if (waited == TIMEOUT_CYCLES) begin
            report_timeout("in_rdy stayed low");
         end
         waited++;
         next_cycle();
      end
      {in_ctrl, in_data} = word;
      in_wr = 1'b1;
      next_cycle();
      in_wr = 1'b0;
   endtask

   task automatic send_packet(input logic [NUM_QUEUES-1:0] dst, input int len);
      word_q_t               words;
      pair_q_t               pairs;
      logic [DATA_WIDTH-1:0] data;
      logic [CTRL_WIDTH-1:0] ctrl;
      for (int w = 0; w < len; w++) begin
         data[DATA_WIDTH-1:32] = next_random();
         data[31:0]            = next_random();
         ctrl                  = '0;
         if (w == 0) begin
            ctrl                            = HDR_CTRL;
            data[HDR_DST_LSB-1:0]           = '0;
            data[HDR_DST_LSB +: NUM_QUEUES] = dst;
            data[HDR_LEN_LSB +: LEN_WIDTH]  = LEN_WIDTH'(len);
         end else if (w == len - 1) begin
            // last word byte mask is all ones about half the time
            ctrl = CTRL_WIDTH'(random_range(1, 254));
            if (random_range(0, 1) == 1) begin
               ctrl = '1;
            end
         end
         words.push_back({ctrl, data});
      end
      pairs = pack_pairs(words);
      for (int q = 0; q < NUM_QUEUES; q++) begin
         if (dst[q]) begin
            if (2 * (QUEUE_DEPTH - model_cnt[q]) > len) begin
               foreach (pairs[p]) begin
                  exp_q[q].push_back(pairs[p]);
               end
               model_cnt[q] += pairs.size();
            end else begin
               dropped++;
            end
         end
      end
      foreach (words[w]) begin
         write_word(words[w]);
      end
   endtask

   task automatic wait_count(input int q);
      int waited;
      waited = 0;
      while (int'(occup_cnt[q]) != model_cnt[q]) begin
         if (waited == TIMEOUT_CYCLES) begin
            report_timeout($sformatf("occup_cnt[%0d] never reached %0d", q, model_cnt[q]));
         end
         waited++;
         next_cycle();
      end
   endtask

   task automatic drain_all();
      int waited;
      int left;
      waited = 0;
      left   = 1;
      while (left != 0) begin
         left = 0;
         for (int q = 0; q < NUM_QUEUES; q++) begin
            left += exp_q[q].size();
         end
         if (left != 0) begin
            if (waited == TIMEOUT_CYCLES) begin
               report_timeout("expected pairs never left the DUT");
            end
            waited++;
            next_cycle();
         end
      end
      next_cycle();
      for (int q = 0; q < NUM_QUEUES; q++) begin
         check_value($sformatf("occup_cnt[%0d] after drain", q), 0, occup_cnt[q]);
      end
   endtask

   task automatic finish_block();
      int waited;
      waited = 0;
      while (dram_pairs < BLOCK_PAIRS) begin
         if (waited == TIMEOUT_CYCLES) begin
            report_timeout("DRAM block never completed");
         end
         waited++;
         next_cycle();
      end
   endtask

   // ------------------------------------------------------------------------
   // comparison of every pair leaving the DUT
   // ------------------------------------------------------------------------
   always @(negedge clk) begin
      if (!reset) begin
         for (int i = 0; i < NUM_QUEUES; i++) begin
            if (hc_wr[i]) begin
               assert (!(xfer_active && i == xfer_queue)) else begin
                  $display("Error in %s: head cache write on queue %0d during its block",
                           test_name, i);
                  errors++;
               end
               check_pair(i, hc_data[i], "head cache");
            end
         end
         if (dram_wr) begin
            assert (xfer_active) else begin
               $display("Error in %s: DRAM write with no block in progress", test_name);
               errors++;
            end
            check_pair(xfer_queue, dram_data, "DRAM");
            dram_pairs++;
            if (dram_pairs == BLOCK_PAIRS) begin
               xfer_active = 1'b0;
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------------------
   initial begin
      reset       = 1'b1;
      in_data     = '0;
      in_ctrl     = '0;
      in_wr       = 1'b0;
      dram_rd     = 1'b0;
      dram_queue  = '0;
      dram_wr_rdy = 1'b0;
      hc_rdy      = '1;
      hc_mask     = '1;
      hc_toggle   = 1'b0;
      dram_toggle = 1'b0;
      lcg_state   = 32'd59261;
      errors      = 0;
      checked     = 0;
      dropped     = 0;
      dram_pairs  = 0;
      xfer_active = 1'b0;
      xfer_queue  = 0;
      test_name   = "reset";
      for (int q = 0; q < NUM_QUEUES; q++) begin
         model_cnt[q] = 0;
      end
      repeat (16) @(posedge clk);
      #2;
      reset = 1'b0;

      check_value("in_rdy", 1, in_rdy);
      check_value("hc_wr", 0, hc_wr);
      check_value("dram_wr", 0, dram_wr);
      check_value("occup_blk", 0, occup_blk);
      for (int q = 0; q < NUM_QUEUES; q++) begin
         check_value($sformatf("occup_cnt[%0d]", q), 0, occup_cnt[q]);
      end

      test_name = "unicast";
      for (int n = 0; n < 12; n++) begin
         send_packet(NUM_QUEUES'(1) << random_range(0, NUM_QUEUES - 1), random_range(3, 24));
      end
      drain_all();

      // random multicast sets under head cache ready toggling
      test_name = "multicast";
      hc_toggle = 1'b1;
      for (int n = 0; n < 16; n++) begin
         send_packet(NUM_QUEUES'(random_range(1, 15)), random_range(3, 20));
      end
      drain_all();
      hc_toggle = 1'b0;

      // queue 1 held at 60 pairs before a drop and an exact fill
      test_name = "drop";
      hc_mask   = ~(NUM_QUEUES'(1) << 1);
      for (int n = 0; n < 5; n++) begin
         send_packet(NUM_QUEUES'(4'b0010), 24);
      end
      wait_count(1);
      send_packet(NUM_QUEUES'(4'b1010), 20);
      send_packet(NUM_QUEUES'(4'b0010), 7);
      wait_count(1);
      check_value("occup_blk[1]", 1, occup_blk[1]);
      hc_mask = '1;
      drain_all();

      // queue 2 held until a block is ready
      test_name = "dram block";
      hc_mask   = ~(NUM_QUEUES'(1) << 2);
      for (int n = 0; n < 3; n++) begin
         send_packet(NUM_QUEUES'(4'b0100), random_range(9, 12));
      end
      wait_count(2);
      check_value("occup_blk[2]", 1, occup_blk[2]);
      dram_queue = QUEUE_BITS'(2);
      dram_rd    = 1'b1;
      next_cycle();
      dram_rd     = 1'b0;
      dram_pairs  = 0;
      xfer_queue  = 2;
      xfer_active = 1'b1;
      dram_toggle = 1'b1;
      hc_mask     = '1;
      finish_block();
      dram_toggle = 1'b0;
      drain_all();
      check_value("DRAM pairs in block", BLOCK_PAIRS, dram_pairs);

      end_run();
   end

endmodule

// File: design/tail_cache.sv
// Tail cache top level
`timescale 1ns/1ps

module tail_cache (
   input  logic                           clk,
   input  logic                           reset,
   input  logic [tc_pkg::DATA_WIDTH-1:0]  in_data,
   input  logic [tc_pkg::CTRL_WIDTH-1:0]  in_ctrl,
   input  logic                           in_wr,
   output logic                           in_rdy,
   input  logic                           dram_rd,
   input  logic [tc_pkg::QUEUE_BITS-1:0]  dram_queue,
   input  logic                           dram_wr_rdy,
   output logic                           dram_wr,
   output logic [tc_pkg::PAIR_WIDTH-1:0]  dram_data,
   input  logic [tc_pkg::NUM_QUEUES-1:0]  hc_rdy,
   output logic [tc_pkg::NUM_QUEUES-1:0]  hc_wr,
   output logic [tc_pkg::PAIR_WIDTH-1:0]  hc_data [tc_pkg::NUM_QUEUES],
   output logic [tc_pkg::COUNT_WIDTH-1:0] occup_cnt [tc_pkg::NUM_QUEUES],
   output logic [tc_pkg::NUM_QUEUES-1:0]  occup_blk
);
   import tc_pkg::*;

   // parser to writer
   logic                  desc_avail;
   logic [NUM_QUEUES-1:0] desc_dst;
   logic [LEN_WIDTH-1:0]  desc_len;
   logic                  desc_pop;
   logic                  parser_rdy;

   // input FIFO
   logic [WORD_WIDTH-1:0] fifo_word;
   logic                  fifo_empty;
   logic                  fifo_rd;
   logic                  fifo_nearly_full;

   // per-queue signals
   logic [NUM_QUEUES-1:0]  q_wr;
   logic [PAIR_WIDTH-1:0]  q_din;
   logic [NUM_QUEUES-1:0]  q_rd;
   logic [PAIR_WIDTH-1:0]  q_dout [NUM_QUEUES];
   logic [NUM_QUEUES-1:0]  q_empty;
   logic [COUNT_WIDTH-1:0] q_count [NUM_QUEUES];

   assign in_rdy = parser_rdy && !fifo_nearly_full;

   tc_header_parser u_parser (
      .clk(clk), .reset(reset), .in_data(in_data), .in_ctrl(in_ctrl),
      .in_wr(in_wr), .desc_pop(desc_pop), .desc_avail(desc_avail),
      .desc_dst(desc_dst), .desc_len(desc_len), .parser_rdy(parser_rdy)
   );

   tc_input_fifo u_input_fifo (
      .clk(clk), .reset(reset), .din({in_ctrl, in_data}), .wr_en(in_wr),
      .rd_en(fifo_rd), .dout(fifo_word), .empty(fifo_empty),
      .nearly_full(fifo_nearly_full)
   );

   for (genvar i = 0; i < NUM_QUEUES; i++) begin : g_queue
      tc_queue_fifo u_queue_fifo (
         .clk(clk), .reset(reset), .wr_en(q_wr[i]), .din(q_din),
         .rd_en(q_rd[i]), .dout(q_dout[i]), .empty(q_empty[i]),
         .data_count(q_count[i])
      );
   end

   tc_pair_writer u_pair_writer (
      .clk(clk), .reset(reset), .desc_avail(desc_avail), .desc_dst(desc_dst),
      .desc_len(desc_len), .fifo_word(fifo_word), .fifo_empty(fifo_empty),
      .q_count(q_count), .desc_pop(desc_pop), .fifo_rd(fifo_rd),
      .q_wr(q_wr), .q_din(q_din)
   );

   tc_drain_ctrl u_drain_ctrl (
      .clk(clk), .reset(reset), .q_dout(q_dout), .q_empty(q_empty),
      .q_count(q_count), .dram_rd(dram_rd), .dram_queue(dram_queue),
      .dram_wr_rdy(dram_wr_rdy), .hc_rdy(hc_rdy), .q_rd(q_rd),
      .dram_wr(dram_wr), .dram_data(dram_data), .hc_wr(hc_wr),
      .hc_data(hc_data), .occup_cnt(occup_cnt), .occup_blk(occup_blk)
   );

endmodule

// File: design/tc_drain_ctrl.sv
// Tail cache drain controller
`timescale 1ns/1ps

module tc_drain_ctrl (
   input  logic                           clk,
   input  logic                           reset,
   input  logic [tc_pkg::PAIR_WIDTH-1:0]  q_dout [tc_pkg::NUM_QUEUES],
   input  logic [tc_pkg::NUM_QUEUES-1:0]  q_empty,
   input  logic [tc_pkg::COUNT_WIDTH-1:0] q_count [tc_pkg::NUM_QUEUES],
   input  logic                           dram_rd,
   input  logic [tc_pkg::QUEUE_BITS-1:0]  dram_queue,
   input  logic                           dram_wr_rdy,
   input  logic [tc_pkg::NUM_QUEUES-1:0]  hc_rdy,
   output logic [tc_pkg::NUM_QUEUES-1:0]  q_rd,
   output logic                           dram_wr,
   output logic [tc_pkg::PAIR_WIDTH-1:0]  dram_data,
   output logic [tc_pkg::NUM_QUEUES-1:0]  hc_wr,
   output logic [tc_pkg::PAIR_WIDTH-1:0]  hc_data [tc_pkg::NUM_QUEUES],
   output logic [tc_pkg::COUNT_WIDTH-1:0] occup_cnt [tc_pkg::NUM_QUEUES],
   output logic [tc_pkg::NUM_QUEUES-1:0]  occup_blk
);
   import tc_pkg::*;

   outp_state_t              state, state_nxt;
   logic [NUM_QUEUES-1:0]    xfer, xfer_nxt;
   logic [BLK_CNT_WIDTH-1:0] pair_cnt, pair_cnt_nxt;
   logic [NUM_QUEUES-1:0]    dram_rd_q;

   // ------------------------------------------------------------------------
   // output FSM, one block per accepted request
   // ------------------------------------------------------------------------
   always_comb begin
      state_nxt    = state;
      xfer_nxt     = xfer;
      pair_cnt_nxt = pair_cnt;
      case (state)
         OUTP_IDLE: begin
            if (dram_rd) begin
               xfer_nxt     = NUM_QUEUES'(1) << dram_queue;
               pair_cnt_nxt = '0;
               state_nxt    = OUTP_TX;
            end
         end
         OUTP_TX: begin
            if (dram_wr) begin
               pair_cnt_nxt = pair_cnt + 1'b1;
            end
            if (pair_cnt_nxt == BLK_CNT_WIDTH'(BLOCK_PAIRS)) begin
               xfer_nxt  = '0;
               state_nxt = OUTP_IDLE;
            end
         end
         default: state_nxt = OUTP_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= OUTP_IDLE;
         xfer     <= '0;
         pair_cnt <= '0;
      end else begin
         state    <= state_nxt;
         xfer     <= xfer_nxt;
         pair_cnt <= pair_cnt_nxt;
      end
   end

   // queue in transfer goes to DRAM, the rest cut through
   assign dram_rd_q = ~q_empty & xfer & {NUM_QUEUES{dram_wr_rdy}};
   assign hc_wr     = ~q_empty & ~xfer & hc_rdy;
   assign q_rd      = dram_rd_q | hc_wr;
   assign dram_wr   = |dram_rd_q;

   always_comb begin
      dram_data = '0;
      for (int i = 0; i < NUM_QUEUES; i++) begin
         if (xfer[i]) begin
            dram_data = q_dout[i];
         end
         hc_data[i]   = q_dout[i];
         occup_cnt[i] = q_count[i];
         occup_blk[i] = (q_count[i] >= COUNT_WIDTH'(BLOCK_PAIRS));
      end
   end

endmodule

// File: design/tc_pair_writer.sv
// Tail cache pair writer
`timescale 1ns/1ps

module tc_pair_writer (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           desc_avail,
   input  logic [tc_pkg::NUM_QUEUES-1:0]  desc_dst,
   input  logic [tc_pkg::LEN_WIDTH-1:0]   desc_len,
   input  logic [tc_pkg::WORD_WIDTH-1:0]  fifo_word,
   input  logic                           fifo_empty,
   input  logic [tc_pkg::COUNT_WIDTH-1:0] q_count [tc_pkg::NUM_QUEUES],
   output logic                           desc_pop,
   output logic                           fifo_rd,
   output logic [tc_pkg::NUM_QUEUES-1:0]  q_wr,
   output logic [tc_pkg::PAIR_WIDTH-1:0]  q_din
);
   import tc_pkg::*;

   inp_state_t            state, state_nxt;
   logic [NUM_QUEUES-1:0] selected, selected_nxt;
   logic                  odd, odd_nxt;
   logic                  prev_zero;
   logic [WORD_WIDTH-1:0] odd_word;
   logic [NUM_QUEUES-1:0] has_space;
   logic [CTRL_WIDTH-1:0] word_ctrl;
   logic                  last_word;

   // room for the whole packet, counted in words
   always_comb begin
      for (int i = 0; i < NUM_QUEUES; i++) begin
         has_space[i] = LEN_WIDTH'((QUEUE_DEPTH - q_count[i]) * 2) > desc_len;
      end
   end

   assign word_ctrl = fifo_word[WORD_WIDTH-1 -: CTRL_WIDTH];
   assign last_word = (word_ctrl != '0) && prev_zero;

   // ------------------------------------------------------------------------
   // input FSM
   // ------------------------------------------------------------------------
   always_comb begin
      state_nxt    = state;
      selected_nxt = selected;
      odd_nxt      = odd;
      desc_pop     = 1'b0;
      fifo_rd      = 1'b0;
      q_wr         = '0;
      q_din        = {odd_word, fifo_word};
      case (state)
         INP_WAIT: begin
            if (desc_avail) begin
               // an empty selection still reads the packet out
               selected_nxt = desc_dst & has_space;
               state_nxt    = INP_STORE;
            end
         end
         INP_STORE: begin
            if (!fifo_empty) begin
               fifo_rd = 1'b1;
               odd_nxt = ~odd;
               if (odd) begin
                  q_wr = selected;
               end
               if (last_word) begin
                  desc_pop  = 1'b1;
                  odd_nxt   = 1'b0;
                  state_nxt = INP_WAIT;
                  if (!odd) begin
                     // lone final word, lower half zero
                     q_wr  = selected;
                     q_din = {fifo_word, {WORD_WIDTH{1'b0}}};
                  end
               end
            end
         end
         default: state_nxt = INP_WAIT;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= INP_WAIT;
         selected  <= '0;
         odd       <= 1'b0;
         prev_zero <= 1'b0;
      end else begin
         state    <= state_nxt;
         selected <= selected_nxt;
         odd      <= odd_nxt;
         if (fifo_rd) begin
            prev_zero <= (word_ctrl == '0);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fifo_rd && !odd) begin
         odd_word <= fifo_word;
      end
   end

endmodule

// File: design/tc_queue_fifo.sv
// Tail cache output queue FIFO
`timescale 1ns/1ps

module tc_queue_fifo (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           wr_en,
   input  logic [tc_pkg::PAIR_WIDTH-1:0]  din,
   input  logic                           rd_en,
   output logic [tc_pkg::PAIR_WIDTH-1:0]  dout,
   output logic                           empty,
   output logic [tc_pkg::COUNT_WIDTH-1:0] data_count
);
   import tc_pkg::*;

   logic [PAIR_WIDTH-1:0]     mem [QUEUE_DEPTH];
   logic [QUEUE_PTR_BITS-1:0] wr_ptr;
   logic [QUEUE_PTR_BITS-1:0] rd_ptr;
   logic                      do_wr;
   logic                      do_rd;

   // a write into a full queue is lost
   assign do_wr = wr_en && (data_count != COUNT_WIDTH'(QUEUE_DEPTH));
   assign do_rd = rd_en && !empty;

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         data_count <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   data_count <= data_count + 1'b1;
            2'b01:   data_count <= data_count - 1'b1;
            default: data_count <= data_count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

   // show-ahead head pair
   assign dout  = mem[rd_ptr];
   assign empty = (data_count == '0);

endmodule

// File: design/tc_input_fifo.sv
// Tail cache input word FIFO
`timescale 1ns/1ps

module tc_input_fifo (
   input  logic                          clk,
   input  logic                          reset,
   input  logic [tc_pkg::WORD_WIDTH-1:0] din,
   input  logic                          wr_en,
   input  logic                          rd_en,
   output logic [tc_pkg::WORD_WIDTH-1:0] dout,
   output logic                          empty,
   output logic                          nearly_full
);
   import tc_pkg::*;

   logic [WORD_WIDTH-1:0]  mem [IN_FIFO_DEPTH];
   logic [IN_PTR_BITS-1:0] wr_ptr;
   logic [IN_PTR_BITS-1:0] rd_ptr;
   logic [IN_PTR_BITS:0]   depth;
   logic                   do_wr;
   logic                   do_rd;

   assign do_wr = wr_en && (depth != (IN_PTR_BITS+1)'(IN_FIFO_DEPTH));
   assign do_rd = rd_en && !empty;

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         depth  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         depth <= depth + (IN_PTR_BITS+1)'(do_wr) - (IN_PTR_BITS+1)'(do_rd);
      end
   end

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

   // head word shows through as soon as it is stored
   assign dout        = mem[rd_ptr];
   assign empty       = (depth == '0);
   assign nearly_full = (depth >= (IN_PTR_BITS+1)'(IN_FIFO_NF));

endmodule

// File: design/tc_header_parser.sv
// Tail cache header parser
`timescale 1ns/1ps

module tc_header_parser (
   input  logic                           clk,
   input  logic                           reset,
   input  logic [tc_pkg::DATA_WIDTH-1:0]  in_data,
   input  logic [tc_pkg::CTRL_WIDTH-1:0]  in_ctrl,
   input  logic                           in_wr,
   input  logic                           desc_pop,
   output logic                           desc_avail,
   output logic [tc_pkg::NUM_QUEUES-1:0]  desc_dst,
   output logic [tc_pkg::LEN_WIDTH-1:0]   desc_len,
   output logic                           parser_rdy
);
   import tc_pkg::*;

   // two-entry descriptor queue
   logic [NUM_QUEUES-1:0] dst_mem [2];
   logic [LEN_WIDTH-1:0]  len_mem [2];
   logic                  wr_ptr;
   logic                  rd_ptr;
   logic [1:0]            desc_cnt;

   logic in_pkt;
   logic prev_zero;
   logic hdr_push;
   logic pkt_end;

   // header is the first HDR_CTRL word outside a packet body
   assign hdr_push = in_wr && (in_ctrl == HDR_CTRL) && !in_pkt && !desc_cnt[1];
   // last word has a byte mask right after a data word
   assign pkt_end  = in_wr && (in_ctrl != '0) && prev_zero;

   always_ff @(posedge clk) begin
      if (reset) begin
         in_pkt    <= 1'b0;
         prev_zero <= 1'b0;
      end else begin
         if (in_wr) begin
            prev_zero <= (in_ctrl == '0);
         end
         if (pkt_end) begin
            in_pkt <= 1'b0;
         end else if (hdr_push) begin
            in_pkt <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr   <= 1'b0;
         rd_ptr   <= 1'b0;
         desc_cnt <= 2'd0;
      end else begin
         if (hdr_push) begin
            wr_ptr <= ~wr_ptr;
         end
         if (desc_pop && desc_avail) begin
            rd_ptr <= ~rd_ptr;
         end
         desc_cnt <= desc_cnt + 2'(hdr_push) - 2'(desc_pop && desc_avail);
      end
   end

   always_ff @(posedge clk) begin
      if (hdr_push) begin
         dst_mem[wr_ptr] <= in_data[HDR_DST_LSB +: NUM_QUEUES];
         len_mem[wr_ptr] <= in_data[HDR_LEN_LSB +: LEN_WIDTH];
      end
   end

   assign desc_avail = (desc_cnt != 2'd0);
   assign desc_dst   = dst_mem[rd_ptr];
   assign desc_len   = len_mem[rd_ptr];
   assign parser_rdy = !desc_cnt[1];

endmodule

// File: design/tc_pkg.sv
// Tail cache shared definitions

package tc_pkg;

   // ------------------------------------------------------------------------
   // word and pair sizes
   // ------------------------------------------------------------------------
   localparam int DATA_WIDTH = 64;
   localparam int CTRL_WIDTH = 8;
   localparam int WORD_WIDTH = DATA_WIDTH + CTRL_WIDTH;
   localparam int PAIR_WIDTH = 2 * WORD_WIDTH;

   // output queues, sized in pairs
   localparam int NUM_QUEUES     = 4;
   localparam int QUEUE_BITS     = $clog2(NUM_QUEUES);
   localparam int QUEUE_DEPTH    = 64;
   localparam int QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);
   localparam int COUNT_WIDTH    = $clog2(QUEUE_DEPTH + 1);

   // one DRAM transfer block
   localparam int BLOCK_PAIRS   = 8;
   localparam int BLK_CNT_WIDTH = $clog2(BLOCK_PAIRS + 1);

   // packet length in words, header included
   localparam int MAX_PKT_WORDS = 256;
   localparam int LEN_WIDTH     = $clog2(MAX_PKT_WORDS + 1);

   // input word FIFO, four entries of slack behind nearly full
   localparam int IN_FIFO_DEPTH = 16;
   localparam int IN_PTR_BITS   = $clog2(IN_FIFO_DEPTH);
   localparam int IN_FIFO_NF    = IN_FIFO_DEPTH - 4;

   // ------------------------------------------------------------------------
   // module header word
   // ------------------------------------------------------------------------
   localparam logic [CTRL_WIDTH-1:0] HDR_CTRL = 8'hFF;
   localparam int HDR_DST_LSB = 16;
   localparam int HDR_LEN_LSB = 0;

   typedef enum logic {INP_WAIT, INP_STORE} inp_state_t;
   typedef enum logic {OUTP_IDLE, OUTP_TX} outp_state_t;

endpackage
